// ==== lsu_pkg.sv ====
// Load/store unit definitions
package lsu_pkg;

   localparam int XLEN   = 32;
   localparam int IMM_W  = 12;
   localparam int STRB_W = XLEN / 8;

   // Bit 3 marks a store and the low three bits follow funct3
   typedef enum logic [3:0] {
      LB  = 4'b0000,
      LH  = 4'b0001,
      LW  = 4'b0010,
      LBU = 4'b0100,
      LHU = 4'b0101,
      SB  = 4'b1000,
      SH  = 4'b1001,
      SW  = 4'b1010
   } mem_op_e;

   function automatic logic is_store(input mem_op_e op);
      return op[3];
   endfunction

   // Zero extension on load, only meaningful for LBU and LHU
   function automatic logic is_unsigned(input mem_op_e op);
      return op[2];
   endfunction

   // Log2 of the access size in bytes
   function automatic logic [1:0] op_size(input mem_op_e op);
      return op[1:0];
   endfunction

endpackage

// ==== ahb_pkg.sv ====
// AHB-Lite bus definitions
package ahb_pkg;

   localparam int HADDR_W = 32;
   localparam int HDATA_W = 32;

   // Only the two transfer types a single-beat master needs
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      NONSEQ = 2'b10
   } htrans_e;

   typedef enum logic [2:0] {
      BYTE = 3'b000,
      HALF = 3'b001,
      WORD = 3'b010
   } hsize_e;

endpackage

// ==== lsu_addr_if.sv ====
// Checked effective address link
`timescale 1ns/1ns

interface lsu_addr_if;

   logic [lsu_pkg::XLEN-1:0] addr;
   ahb_pkg::hsize_e          size;
   logic                     write;
   logic                     misaligned;

   // Address unit side
   modport agu (
      output addr,
      output size,
      output write,
      output misaligned
   );

   // Bus controller side
   modport ctrl (
      input addr,
      input size,
      input write,
      input misaligned
   );

endinterface

// ==== lsu_agu.sv ====
// Address generation unit
`timescale 1ns/1ns

module lsu_agu (
   input  lsu_pkg::mem_op_e          cmd_op,
   input  logic [lsu_pkg::XLEN-1:0]  cmd_base,
   input  logic [lsu_pkg::IMM_W-1:0] cmd_imm,
   lsu_addr_if.agu                   addr_o
);

   logic [lsu_pkg::XLEN-1:0] imm_sext;
   logic [lsu_pkg::XLEN-1:0] eff_addr;
   ahb_pkg::hsize_e          size;
   logic                     misaligned;

   assign imm_sext = {{(lsu_pkg::XLEN - lsu_pkg::IMM_W){cmd_imm[lsu_pkg::IMM_W-1]}},
                      cmd_imm};
   assign eff_addr = cmd_base + imm_sext;

   // Op size code maps straight onto hsize
   assign size = ahb_pkg::hsize_e'({1'b0, lsu_pkg::op_size(cmd_op)});

   always_comb begin
      case (size)
         ahb_pkg::HALF: misaligned = eff_addr[0];
         ahb_pkg::WORD: misaligned = |eff_addr[1:0];
         default:       misaligned = 1'b0;
      endcase
   end

   assign addr_o.addr       = eff_addr;
   assign addr_o.size       = size;
   assign addr_o.write      = lsu_pkg::is_store(cmd_op);
   assign addr_o.misaligned = misaligned;

endmodule

// ==== lsu_store_align.sv ====
// Store data lane placement
`timescale 1ns/1ns

module lsu_store_align (
   input  lsu_pkg::mem_op_e            cmd_op,
   input  logic [lsu_pkg::XLEN-1:0]    cmd_wdata,
   input  logic [1:0]                  addr_lo,
   output logic [lsu_pkg::XLEN-1:0]    lane_data,
   output logic [lsu_pkg::STRB_W-1:0]  lane_strb
);

   logic [4:0] byte_shift;
   logic [4:0] half_shift;

   // Bit offsets of the addressed byte and half
   assign byte_shift = {addr_lo, 3'b000};
   assign half_shift = {addr_lo[1], 4'b0000};

   always_comb begin
      case (cmd_op)
         lsu_pkg::SB: begin
            lane_data = lsu_pkg::XLEN'(cmd_wdata[7:0]) << byte_shift;
            lane_strb = 4'b0001 << addr_lo;
         end
         lsu_pkg::SH: begin
            lane_data = lsu_pkg::XLEN'(cmd_wdata[15:0]) << half_shift;
            lane_strb = 4'b0011 << {addr_lo[1], 1'b0};
         end
         lsu_pkg::SW: begin
            lane_data = cmd_wdata;
            lane_strb = 4'b1111;
         end
         // Loads carry no write data
         default: begin
            lane_data = '0;
            lane_strb = '0;
         end
      endcase
   end

endmodule

// ==== lsu_load_extract.sv ====
// Load data extraction
`timescale 1ns/1ns

module lsu_load_extract (
   input  lsu_pkg::mem_op_e          op,
   input  logic [1:0]                addr_lo,
   input  logic [lsu_pkg::XLEN-1:0]  bus_rdata,
   output logic [lsu_pkg::XLEN-1:0]  load_data
);

   logic [7:0]  byte_sel;
   logic [15:0] half_sel;
   logic        byte_fill;
   logic        half_fill;

   // Pick the addressed lane out of the bus word
   assign byte_sel = bus_rdata[{addr_lo, 3'b000} +: 8];
   assign half_sel = addr_lo[1] ? bus_rdata[31:16] : bus_rdata[15:0];

   // Sign bit, or zero for unsigned loads
   assign byte_fill = byte_sel[7] & ~lsu_pkg::is_unsigned(op);
   assign half_fill = half_sel[15] & ~lsu_pkg::is_unsigned(op);

   always_comb begin
      case (op)
         lsu_pkg::LB, lsu_pkg::LBU: begin
            load_data = {{(lsu_pkg::XLEN - 8){byte_fill}}, byte_sel};
         end
         lsu_pkg::LH, lsu_pkg::LHU: begin
            load_data = {{(lsu_pkg::XLEN - 16){half_fill}}, half_sel};
         end
         lsu_pkg::LW: begin
            load_data = bus_rdata;
         end
         default: begin
            load_data = '0;
         end
      endcase
   end

endmodule

// ==== lsu_bus_ctrl.sv ====
// AHB-Lite bus controller
`timescale 1ns/1ns

module lsu_bus_ctrl (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          cmd_valid,
   output logic                          cmd_ready,
   input  lsu_pkg::mem_op_e              cmd_op,
   lsu_addr_if.ctrl                      addr_i,
   input  logic [lsu_pkg::XLEN-1:0]      lane_data,
   input  logic [lsu_pkg::STRB_W-1:0]    lane_strb,
   output logic [ahb_pkg::HADDR_W-1:0]   haddr,
   output ahb_pkg::htrans_e              htrans,
   output logic                          hwrite,
   output ahb_pkg::hsize_e               hsize,
   output logic [ahb_pkg::HDATA_W-1:0]   hwdata,
   input  logic [ahb_pkg::HDATA_W-1:0]   hrdata,
   input  logic                          hready,
   output logic                          rsp_valid,
   output logic [lsu_pkg::XLEN-1:0]      rsp_rdata,
   output logic                          rsp_misaligned
);

   typedef enum logic [1:0] {
      IDLE,
      ADDR,
      DATA,
      RESP
   } state_e;

   state_e                   state;
   state_e                   state_nxt;
   logic                     accept;
   logic [lsu_pkg::XLEN-1:0] load_data;

   // Command captured at acceptance
   logic [lsu_pkg::XLEN-1:0] addr_q;
   ahb_pkg::hsize_e          size_q;
   logic                     write_q;
   lsu_pkg::mem_op_e         op_q;
   logic [lsu_pkg::XLEN-1:0] wdata_q;

   // Response
   logic [lsu_pkg::XLEN-1:0] rdata_q;
   logic                     mis_q;
   logic                     rsp_valid_q;

   assign cmd_ready = (state == IDLE);
   assign accept    = cmd_valid & cmd_ready;

   // ========================================================================
   // Phase sequencing
   // ========================================================================

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: if (accept) state_nxt = addr_i.misaligned ? RESP : ADDR;
         ADDR: if (hready) state_nxt = DATA;
         DATA: if (hready) state_nxt = RESP;
         RESP: state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= IDLE;
         mis_q       <= 1'b0;
         rsp_valid_q <= 1'b0;
      end else begin
         state       <= state_nxt;
         rsp_valid_q <= (state == RESP);
         if (accept) mis_q <= addr_i.misaligned;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q  <= addr_i.addr;
         size_q  <= addr_i.size;
         write_q <= addr_i.write;
         op_q    <= cmd_op;
         wdata_q <= lane_data;
      end
      // Misaligned and store responses return zero
      if (accept && addr_i.misaligned) begin
         rdata_q <= '0;
      end else if (state == DATA && hready) begin
         rdata_q <= write_q ? '0 : load_data;
      end
   end

   lsu_load_extract u_load_extract (
      .op        (op_q),
      .addr_lo   (addr_q[1:0]),
      .bus_rdata (hrdata),
      .load_data (load_data)
   );

   // ========================================================================
   // Bus and response outputs
   // ========================================================================

   assign haddr  = addr_q;
   assign htrans = (state == ADDR) ? ahb_pkg::NONSEQ : ahb_pkg::IDLE;
   assign hwrite = write_q;
   assign hsize  = size_q;
   assign hwdata = wdata_q;

   assign rsp_valid      = rsp_valid_q;
   assign rsp_rdata      = rdata_q;
   assign rsp_misaligned = mis_q;

endmodule

// ==== lsu_top.sv ====
// Load/store unit top level
`timescale 1ns/1ns

module lsu_top (
   input  logic                          clk,
   input  logic                          rst_n,
   // Command
   input  logic                          cmd_valid,
   output logic                          cmd_ready,
   input  lsu_pkg::mem_op_e              cmd_op,
   input  logic [lsu_pkg::XLEN-1:0]      cmd_base,
   input  logic [lsu_pkg::IMM_W-1:0]     cmd_imm,
   input  logic [lsu_pkg::XLEN-1:0]      cmd_wdata,
   // AHB-Lite master
   output logic [ahb_pkg::HADDR_W-1:0]   haddr,
   output ahb_pkg::htrans_e              htrans,
   output logic                          hwrite,
   output ahb_pkg::hsize_e               hsize,
   output logic [ahb_pkg::HDATA_W-1:0]   hwdata,
   input  logic [ahb_pkg::HDATA_W-1:0]   hrdata,
   input  logic                          hready,
   // Response
   output logic                          rsp_valid,
   output logic [lsu_pkg::XLEN-1:0]      rsp_rdata,
   output logic                          rsp_misaligned
);

   logic [lsu_pkg::XLEN-1:0]   lane_data;
   logic [lsu_pkg::STRB_W-1:0] lane_strb;

   lsu_addr_if u_addr_if ();

   lsu_agu u_agu (
      .cmd_op   (cmd_op),
      .cmd_base (cmd_base),
      .cmd_imm  (cmd_imm),
      .addr_o   (u_addr_if.agu)
   );

   lsu_store_align u_store_align (
      .cmd_op    (cmd_op),
      .cmd_wdata (cmd_wdata),
      .addr_lo   (u_addr_if.addr[1:0]),
      .lane_data (lane_data),
      .lane_strb (lane_strb)
   );

   lsu_bus_ctrl u_bus_ctrl (
      .clk            (clk),
      .rst_n          (rst_n),
      .cmd_valid      (cmd_valid),
      .cmd_ready      (cmd_ready),
      .cmd_op         (cmd_op),
      .addr_i         (u_addr_if.ctrl),
      .lane_data      (lane_data),
      .lane_strb      (lane_strb),
      .haddr          (haddr),
      .htrans         (htrans),
      .hwrite         (hwrite),
      .hsize          (hsize),
      .hwdata         (hwdata),
      .hrdata         (hrdata),
      .hready         (hready),
      .rsp_valid      (rsp_valid),
      .rsp_rdata      (rsp_rdata),
      .rsp_misaligned (rsp_misaligned)
   );

endmodule

// ==== tb_ahb_mem.sv ====
// AHB-Lite slave memory model
`timescale 1ns/1ns

module tb_ahb_mem (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [ahb_pkg::HADDR_W-1:0]  haddr,
   input  ahb_pkg::htrans_e             htrans,
   input  logic                         hwrite,
   input  ahb_pkg::hsize_e              hsize,
   input  logic [ahb_pkg::HDATA_W-1:0]  hwdata,
   output logic [ahb_pkg::HDATA_W-1:0]  hrdata,
   output logic                         hready
);

   logic [7:0]      mem [256];
   logic [1:0]      wait_cnt;
   logic            dphase;
   logic            dwrite;
   logic [7:0]      daddr;
   ahb_pkg::hsize_e dsize;

   // Byte lanes touched by a transfer of this size
   function automatic logic lane_hit(input ahb_pkg::hsize_e size, input logic [1:0] lo,
                                     input logic [1:0] lane);
      case (size)
         ahb_pkg::BYTE: return lane == lo;
         ahb_pkg::HALF: return lane[1] == lo[1];
         default:       return 1'b1;
      endcase
   endfunction

   assign hready = (wait_cnt == 2'd0);
   assign hrdata = {mem[{daddr[7:2], 2'd3}], mem[{daddr[7:2], 2'd2}],
                    mem[{daddr[7:2], 2'd1}], mem[{daddr[7:2], 2'd0}]};

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wait_cnt <= 2'd0;
         dphase   <= 1'b0;
         dwrite   <= 1'b0;
         daddr    <= 8'h00;
         dsize    <= ahb_pkg::BYTE;
         // Each byte starts out holding its own address
         for (int i = 0; i < 256; i++) begin
            mem[i] <= 8'(i);
         end
      end else begin
         // Fresh stall count of 0 to 2 cycles for the next phase
         if (hready) begin
            wait_cnt <= 2'($urandom % 3);
         end else begin
            wait_cnt <= wait_cnt - 1'b1;
         end
         if (hready) begin
            if (dphase && dwrite) begin
               for (int k = 0; k < 4; k++) begin
                  if (lane_hit(dsize, daddr[1:0], 2'(k))) begin
                     mem[{daddr[7:2], 2'(k)}] <= hwdata[8*k +: 8];
                  end
               end
            end
            dphase <= (htrans == ahb_pkg::NONSEQ);
            dwrite <= hwrite;
            daddr  <= haddr[7:0];
            dsize  <= hsize;
         end
      end
   end

endmodule

// ==== lsu_chk.sv ====
// Bus controller assertions
`timescale 1ns/1ns

module lsu_chk (
   input logic                         clk,
   input logic                         rst_n,
   input logic                         cmd_ready,
   input ahb_pkg::htrans_e             htrans,
   input logic [ahb_pkg::HADDR_W-1:0]  haddr,
   input ahb_pkg::hsize_e              hsize,
   input logic                         hready,
   input logic                         rsp_valid,
   input logic                         mis_q,
   input logic [lsu_pkg::STRB_W-1:0]   lane_strb
);

   int violations = 0;

   task automatic report_violation(input string what);
      $error("%s", what);
      violations++;
   endtask

   // Address phase held while the slave stalls
   a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (htrans == ahb_pkg::NONSEQ && !hready) |=>
         (htrans == ahb_pkg::NONSEQ && $stable(haddr) && $stable(hsize)))
      else report_violation("address phase changed while hready was low");

   a_rsp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid |=> !rsp_valid)
      else report_violation("rsp_valid high for two cycles in a row");

   a_no_mis_xfer: assert property (@(posedge clk) disable iff (!rst_n)
      (htrans == ahb_pkg::NONSEQ) |-> !mis_q)
      else report_violation("bus transfer started for a misaligned command");

   a_busy: assert property (@(posedge clk) disable iff (!rst_n)
      (htrans != ahb_pkg::IDLE) |-> !cmd_ready)
      else report_violation("cmd_ready high during a bus transfer");

   // Legal byte strobe patterns only
   a_strb: assert property (@(posedge clk) disable iff (!rst_n)
      lane_strb inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC, 4'hF})
      else report_violation("illegal store byte strobe pattern");

endmodule

bind lsu_bus_ctrl lsu_chk u_chk (.*);

// ==== tb_lsu_top.sv ====
// Load/store unit testbench
`timescale 1ns/1ns

module tb_lsu_top;

   localparam int N_ROWS = 24;
   localparam int LIMIT  = N_ROWS * 20 + 100;

   typedef struct packed {
      lsu_pkg::mem_op_e op;
      logic [31:0]      base;
      logic [11:0]      imm;
      logic [31:0]      wdata;
      logic [31:0]      exp_rdata;
      logic             exp_mis;
   } row_t;

   // Memory starts with each byte equal to its address
   localparam row_t ROWS [N_ROWS] = '{
      '{lsu_pkg::SW,  32'h40, 12'h000, 32'hA1B2C3D4, 32'h00000000, 1'b0},
      '{lsu_pkg::LW,  32'h40, 12'h000, 32'h0,        32'hA1B2C3D4, 1'b0},
      '{lsu_pkg::SB,  32'h50, 12'h001, 32'hAAAAAAF5, 32'h00000000, 1'b0},
      '{lsu_pkg::LB,  32'h50, 12'h001, 32'h0,        32'hFFFFFFF5, 1'b0},
      '{lsu_pkg::LBU, 32'h50, 12'h001, 32'h0,        32'h000000F5, 1'b0},
      '{lsu_pkg::LW,  32'h50, 12'h000, 32'h0,        32'h5352F550, 1'b0},
      '{lsu_pkg::LB,  32'h80, 12'h000, 32'h0,        32'hFFFFFF80, 1'b0},
      '{lsu_pkg::LB,  32'h80, 12'h001, 32'h0,        32'hFFFFFF81, 1'b0},
      '{lsu_pkg::LB,  32'h80, 12'h002, 32'h0,        32'hFFFFFF82, 1'b0},
      '{lsu_pkg::LB,  32'h80, 12'h003, 32'h0,        32'hFFFFFF83, 1'b0},
      '{lsu_pkg::LBU, 32'h80, 12'h003, 32'h0,        32'h00000083, 1'b0},
      '{lsu_pkg::SH,  32'h60, 12'h000, 32'h12349ABC, 32'h00000000, 1'b0},
      '{lsu_pkg::SH,  32'h64, 12'h002, 32'h5678C3D2, 32'h00000000, 1'b0},
      '{lsu_pkg::LH,  32'h60, 12'h000, 32'h0,        32'hFFFF9ABC, 1'b0},
      '{lsu_pkg::LHU, 32'h60, 12'h000, 32'h0,        32'h00009ABC, 1'b0},
      '{lsu_pkg::LH,  32'h64, 12'h002, 32'h0,        32'hFFFFC3D2, 1'b0},
      '{lsu_pkg::LHU, 32'h64, 12'h002, 32'h0,        32'h0000C3D2, 1'b0},
      '{lsu_pkg::LW,  32'h60, 12'h000, 32'h0,        32'h63629ABC, 1'b0},
      '{lsu_pkg::LW,  32'h68, 12'h000, 32'h0,        32'h6B6A6968, 1'b0},
      '{lsu_pkg::LBU, 32'hA0, 12'hFF0, 32'h0,        32'h00000090, 1'b0},
      '{lsu_pkg::LW,  32'hA4, 12'hFE0, 32'h0,        32'h87868584, 1'b0},
      '{lsu_pkg::LH,  32'h70, 12'h001, 32'h0,        32'h00000000, 1'b1},
      '{lsu_pkg::SW,  32'h70, 12'h002, 32'hDEADBEEF, 32'h00000000, 1'b1},
      '{lsu_pkg::LW,  32'h70, 12'h000, 32'h0,        32'h73727170, 1'b0}
   };

   logic                  clk;
   logic                  rst_n;
   logic                  cmd_valid;
   logic                  cmd_ready;
   lsu_pkg::mem_op_e      cmd_op;
   logic [31:0]           cmd_base;
   logic [11:0]           cmd_imm;
   logic [31:0]           cmd_wdata;
   logic [31:0]           haddr;
   ahb_pkg::htrans_e      htrans;
   logic                  hwrite;
   ahb_pkg::hsize_e       hsize;
   logic [31:0]           hwdata;
   logic [31:0]           hrdata;
   logic                  hready;
   logic                  rsp_valid;
   logic [31:0]           rsp_rdata;
   logic                  rsp_misaligned;

   lsu_top u_lsu_top (.*);

   tb_ahb_mem u_mem (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // ========================================================================
   // Table walk
   // ========================================================================

   initial begin
      int pass_cnt;
      int fail_cnt;
      int chk_fails;
      bit row_bad;
      pass_cnt  = 0;
      fail_cnt  = 0;
      void'($urandom(20136));
      rst_n     = 1'b0;
      cmd_valid = 1'b0;
      cmd_op    = lsu_pkg::LB;
      cmd_base  = '0;
      cmd_imm   = '0;
      cmd_wdata = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int r = 0; r < N_ROWS; r++) begin
         @(negedge clk);
         cmd_valid = 1'b1;
         cmd_op    = ROWS[r].op;
         cmd_base  = ROWS[r].base;
         cmd_imm   = ROWS[r].imm;
         cmd_wdata = ROWS[r].wdata;
         while (!cmd_ready) @(negedge clk);
         // Taken at the rising edge in between
         @(negedge clk);
         cmd_valid = 1'b0;
         while (!rsp_valid) @(negedge clk);
         row_bad = 1'b0;
         if (rsp_rdata !== ROWS[r].exp_rdata) begin
            $display("[FAIL] %0t rsp_rdata expected %h got %h",
                     $time, ROWS[r].exp_rdata, rsp_rdata);
            row_bad = 1'b1;
         end
         if (rsp_misaligned !== ROWS[r].exp_mis) begin
            $display("[FAIL] %0t rsp_misaligned expected %b got %b",
                     $time, ROWS[r].exp_mis, rsp_misaligned);
            row_bad = 1'b1;
         end
         if (row_bad) begin
            fail_cnt++;
         end else begin
            pass_cnt++;
         end
         $display("row %0d %s addr %h: %s", r, ROWS[r].op.name(),
                  ROWS[r].base + {{20{ROWS[r].imm[11]}}, ROWS[r].imm},
                  row_bad ? "failed" : "passed");
      end
      chk_fails = u_lsu_top.u_bus_ctrl.u_chk.violations;
      if (chk_fails != 0) begin
         $display("Bus controller assertions failed %0d times", chk_fails);
      end
      $display("Rows passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && chk_fails == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // Watchdog scaled by the table length
   initial begin
      repeat (LIMIT) @(posedge clk);
      $display("Timeout after %0d cycles, a response never arrived", LIMIT);
      $display("Something failed");
      $finish;
   end

endmodule

// ==== all.f ====
lsu_pkg.sv
ahb_pkg.sv
lsu_addr_if.sv
lsu_agu.sv
lsu_store_align.sv
lsu_load_extract.sv
lsu_bus_ctrl.sv
lsu_top.sv
tb_ahb_mem.sv
lsu_chk.sv
tb_lsu_top.sv

// ==== Makefile ====
TOP = tb_lsu_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f -o sim

run: compile
	./obj_dir/sim +verilator+error+limit+1000 | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
